// ==== rtl/delay_pkg.sv ====
`default_nettype none

package delay_pkg;

    // Coordinate and difference widths.
    localparam int coord_w = 16;          // Signed coordinate of an element or a focal point.
    localparam int diff_w  = 16;          // Magnitude of a coordinate difference.

    // Sum of two squared differences, one extra bit so the add never overflows.
    localparam int sum_w   = 33;

    // The floor of the root of a 33-bit value fits in 17 bits.
    localparam int root_w  = 17;

    localparam int elem_w  = 7;           // Element tag, up to 128 elements.

    // Output delay in sample units.
    localparam int delay_w    = 8;
    localparam int dist_shift = 2;        // Distance units per sample as a power of two.
    localparam int delay_max  = 255;      // Largest delay that can be reported.

    // One root bit is resolved per pipeline stage.
    localparam int sqrt_stages = root_w;

    // Decode, two square-sum stages, the root pipeline and the result register.
    localparam int calc_latency = 1 + 2 + sqrt_stages + 1;

endpackage

`default_nettype wire

// ==== rtl/dist_if.sv ====
`default_nettype none

interface dist_if;
    import delay_pkg::*;

    logic              valid;   // One-cycle request strobe.
    logic [diff_w-1:0] dx;      // Absolute x difference.
    logic [diff_w-1:0] dz;      // Absolute z difference.
    logic [elem_w-1:0] elem;    // Element tag that travels with the request.

    modport src (
        output valid,
        output dx,
        output dz,
        output elem
    );

    modport dst (
        input valid,
        input dx,
        input dz,
        input elem
    );

endinterface

`default_nettype wire

// ==== rtl/delay_decode.sv ====
`default_nettype none

module delay_decode (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic signed [delay_pkg::coord_w-1:0] x_elem,
    input  logic signed [delay_pkg::coord_w-1:0] z_elem,
    input  logic signed [delay_pkg::coord_w-1:0] x_focus,
    input  logic signed [delay_pkg::coord_w-1:0] z_focus,
    input  logic        [delay_pkg::elem_w-1:0]  elem,
    dist_if.src                                  req
);
    import delay_pkg::*;

    logic signed [coord_w:0] x_diff;
    logic signed [coord_w:0] z_diff;
    logic        [coord_w:0] x_mag;
    logic        [coord_w:0] z_mag;

    // The difference of two 16-bit signed values needs 17 bits.
    always_comb begin
        x_diff = x_focus - x_elem;
        z_diff = z_focus - z_elem;
        x_mag  = x_diff[coord_w] ? -x_diff : x_diff;
        z_mag  = z_diff[coord_w] ? -z_diff : z_diff;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= start;
        end
    end

    // The magnitude is at most 65535, so the top bit is always clear.
    always_ff @(posedge clk) begin
        if (start) begin
            req.dx   <= x_mag[diff_w-1:0];
            req.dz   <= z_mag[diff_w-1:0];
            req.elem <= elem;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dist_square_sum.sv ====
`default_nettype none

module dist_square_sum (
    input  logic                          clk,
    input  logic                          reset,
    dist_if.dst                           req,
    output logic                          sq_valid,
    output logic [delay_pkg::sum_w-1:0]   sum_sq,
    output logic [delay_pkg::elem_w-1:0]  sq_elem
);
    import delay_pkg::*;

    logic                  prod_valid;
    logic [2*diff_w-1:0]   dx_sq;
    logic [2*diff_w-1:0]   dz_sq;
    logic [elem_w-1:0]     prod_elem;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
            sq_valid   <= 1'b0;
        end else begin
            prod_valid <= req.valid;
            sq_valid   <= prod_valid;
        end
    end

    // First stage forms both squares.
    always_ff @(posedge clk) begin
        dx_sq     <= req.dx * req.dx;
        dz_sq     <= req.dz * req.dz;
        prod_elem <= req.elem;
    end

    // Second stage adds them at the wider sum width.
    always_ff @(posedge clk) begin
        sum_sq  <= sum_w'(dx_sq) + sum_w'(dz_sq);
        sq_elem <= prod_elem;
    end

endmodule

`default_nettype wire

// ==== rtl/isqrt_pipe.sv ====
`default_nettype none

module isqrt_pipe (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          sq_valid,
    input  logic [delay_pkg::sum_w-1:0]   sum_sq,
    input  logic [delay_pkg::elem_w-1:0]  sq_elem,
    output logic                          root_valid,
    output logic [delay_pkg::root_w-1:0]  root,
    output logic [delay_pkg::elem_w-1:0]  root_elem
);
    import delay_pkg::*;

    // Index 0 is the operand at the input; index k holds the state after k stages.
    logic                  stage_valid [sqrt_stages+1];
    logic [2*root_w-1:0]   stage_rad   [sqrt_stages+1];
    logic [root_w+1:0]     stage_rem   [sqrt_stages+1];
    logic [root_w-1:0]     stage_root  [sqrt_stages+1];
    logic [elem_w-1:0]     stage_elem  [sqrt_stages+1];

    // The radicand is padded to an even width so bits come down in pairs.
    assign stage_valid[0] = sq_valid;
    assign stage_rad[0]   = {{(2*root_w-sum_w){1'b0}}, sum_sq};
    assign stage_rem[0]   = '0;
    assign stage_root[0]  = '0;
    assign stage_elem[0]  = sq_elem;

    for (genvar i = 0; i < sqrt_stages; i++) begin : g_stage
        logic [root_w+1:0] shifted;
        logic [root_w+1:0] trial;

        // The remainder never exceeds twice the partial root, so its top two bits are free.
        assign shifted = {stage_rem[i][root_w-1:0], stage_rad[i][2*root_w-1 -: 2]};
        assign trial   = {stage_root[i], 2'b01};

        always_ff @(posedge clk) begin
            if (reset) begin
                stage_valid[i+1] <= 1'b0;
            end else begin
                stage_valid[i+1] <= stage_valid[i];
            end
        end

        always_ff @(posedge clk) begin
            stage_rad[i+1]  <= {stage_rad[i][2*root_w-3:0], 2'b00};
            stage_elem[i+1] <= stage_elem[i];
            if (shifted >= trial) begin
                stage_rem[i+1]  <= shifted - trial;    // Trial bit is kept.
                stage_root[i+1] <= {stage_root[i][root_w-2:0], 1'b1};
            end else begin
                stage_rem[i+1]  <= shifted;            // Restore and clear the bit.
                stage_root[i+1] <= {stage_root[i][root_w-2:0], 1'b0};
            end
        end
    end

    assign root_valid = stage_valid[sqrt_stages];
    assign root       = stage_root[sqrt_stages];
    assign root_elem  = stage_elem[sqrt_stages];

endmodule

`default_nettype wire

// ==== rtl/delay_result.sv ====
`default_nettype none

module delay_result (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          root_valid,
    input  logic [delay_pkg::root_w-1:0]  root,
    input  logic [delay_pkg::elem_w-1:0]  root_elem,
    output logic [delay_pkg::delay_w-1:0] delay_out,
    output logic [delay_pkg::elem_w-1:0]  elem_out,
    output logic                          done
);
    import delay_pkg::*;

    logic [root_w-1:0]  scaled;
    logic [delay_w-1:0] delay_sat;

    always_comb begin
        scaled = root >> dist_shift;
        if (scaled > delay_max) begin
            delay_sat = delay_w'(delay_max);    // Focus is beyond the sample window.
        end else begin
            delay_sat = scaled[delay_w-1:0];
        end
    end

    // The outputs hold between strobes.
    always_ff @(posedge clk) begin
        if (reset) begin
            delay_out <= '0;
            elem_out  <= '0;
            done      <= 1'b0;
        end else begin
            done <= root_valid;
            if (root_valid) begin
                delay_out <= delay_sat;
                elem_out  <= root_elem;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/delay_calc_top.sv ====
`default_nettype none

module delay_calc_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic signed [delay_pkg::coord_w-1:0] x_elem,
    input  logic signed [delay_pkg::coord_w-1:0] z_elem,
    input  logic signed [delay_pkg::coord_w-1:0] x_focus,
    input  logic signed [delay_pkg::coord_w-1:0] z_focus,
    input  logic        [delay_pkg::elem_w-1:0]  elem,
    output logic        [delay_pkg::delay_w-1:0] delay_out,
    output logic        [delay_pkg::elem_w-1:0]  elem_out,
    output logic                                 done
);
    import delay_pkg::*;

    dist_if req_if ();

    logic              sq_valid;
    logic [sum_w-1:0]  sum_sq;
    logic [elem_w-1:0] sq_elem;
    logic              root_valid;
    logic [root_w-1:0] root;
    logic [elem_w-1:0] root_elem;

    delay_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .x_elem  (x_elem),
        .z_elem  (z_elem),
        .x_focus (x_focus),
        .z_focus (z_focus),
        .elem    (elem),
        .req     (req_if.src)
    );

    dist_square_sum u_square_sum (
        .clk      (clk),
        .reset    (reset),
        .req      (req_if.dst),
        .sq_valid (sq_valid),
        .sum_sq   (sum_sq),
        .sq_elem  (sq_elem)
    );

    isqrt_pipe u_isqrt (
        .clk        (clk),
        .reset      (reset),
        .sq_valid   (sq_valid),
        .sum_sq     (sum_sq),
        .sq_elem    (sq_elem),
        .root_valid (root_valid),
        .root       (root),
        .root_elem  (root_elem)
    );

    delay_result u_result (
        .clk        (clk),
        .reset      (reset),
        .root_valid (root_valid),
        .root       (root),
        .root_elem  (root_elem),
        .delay_out  (delay_out),
        .elem_out   (elem_out),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== tests/delay_calc_tb.sv ====
`default_nettype none

module delay_calc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import delay_pkg::*;

    typedef logic signed [coord_w-1:0] coord_t;

    localparam int clk_period    = 4;
    localparam int reset_cycles  = 8;
    localparam int random_count  = 40;
    localparam int margin_cycles = 64;

    logic               clk;
    logic               reset;
    logic               start;
    coord_t             x_elem;
    coord_t             z_elem;
    coord_t             x_focus;
    coord_t             z_focus;
    logic [elem_w-1:0]  elem;
    logic [delay_w-1:0] delay_out;
    logic [elem_w-1:0]  elem_out;
    logic               done;

    // Stimulus table, one entry per request.
    string             name_q[$];
    coord_t            xe_q[$];
    coord_t            ze_q[$];
    coord_t            xf_q[$];
    coord_t            zf_q[$];
    logic [elem_w-1:0] tag_q[$];
    int                delay_q[$];
    int                gap_q[$];

    // Requests in flight, oldest first.
    string             pend_name_q[$];
    int                pend_delay_q[$];
    int                pend_tag_q[$];
    int                start_cycle_q[$];

    int seed         = 32'hc0a530d9;
    int fail_count   = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_cnt    = 0;
    int limit_cycles = 0;
    bit seen_start   = 1'b0;

    delay_calc_top DUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .x_elem    (x_elem),
        .z_elem    (z_elem),
        .x_focus   (x_focus),
        .z_focus   (z_focus),
        .elem      (elem),
        .delay_out (delay_out),
        .elem_out  (elem_out),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %0d, actual %0d", name, what, expected, actual);
            fail_count++;
        end
    endtask

    function automatic void add_case(input string name, input int xe, input int ze,
                                     input int xf, input int zf, input int tag,
                                     input int exp_delay, input int gap);
        name_q.push_back(name);
        xe_q.push_back(coord_t'(xe));
        ze_q.push_back(coord_t'(ze));
        xf_q.push_back(coord_t'(xf));
        zf_q.push_back(coord_t'(zf));
        tag_q.push_back(elem_w'(tag));
        delay_q.push_back(exp_delay);
        gap_q.push_back(gap);
    endfunction

    // Floor root found by testing squares, one bit at a time from the top.
    function automatic int ref_delay(input coord_t xe, input coord_t ze,
                                     input coord_t xf, input coord_t zf);
        longint dx;
        longint dz;
        longint sum;
        longint r;
        longint t;
        dx = longint'(xf) - longint'(xe);
        dz = longint'(zf) - longint'(ze);
        if (dx < 0) dx = -dx;
        if (dz < 0) dz = -dz;
        sum = dx * dx + dz * dz;
        r = 0;
        for (int b = root_w; b >= 0; b--) begin
            t = r + (longint'(1) << b);
            if (t * t <= sum) r = t;
        end
        r = r >> dist_shift;
        if (r > delay_max) r = delay_max;
        return int'(r);
    endfunction

    function automatic coord_t rand_coord(input bit wide);
        int v;
        v = $random(seed);
        if (wide) return coord_t'(v);
        return coord_t'(v % 512);    // Keeps most results below saturation.
    endfunction

    always @(posedge clk) begin : monitor
        string name;
        int    exp_delay;
        int    exp_tag;
        int    start_cycle;
        int    errs_before;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > 1 && !seen_start) begin
            check_value("reset", "done", 0, done);
            check_value("reset", "delay_out", 0, delay_out);
            check_value("reset", "elem_out", 0, elem_out);
        end
        if (!reset && start) begin
            if (!seen_start) begin
                seen_start = 1'b1;
                tests_run++;
                if (fail_count == 0) begin
                    $display("test reset: pass");
                end else begin
                    $display("test reset: failed");
                    tests_failed++;
                end
            end
            start_cycle_q.push_back(cycle_cnt);
        end
        if (!reset && done === 1'b1) begin
            if (pend_delay_q.size() == 0 || start_cycle_q.size() == 0) begin
                $display("Error: done pulsed at cycle %0d with no request in flight", cycle_cnt);
                fail_count++;
            end else begin
                name        = pend_name_q.pop_front();
                exp_delay   = pend_delay_q.pop_front();
                exp_tag     = pend_tag_q.pop_front();
                start_cycle = start_cycle_q.pop_front();
                errs_before = fail_count;
                check_value(name, "delay", exp_delay, delay_out);
                check_value(name, "tag", exp_tag, elem_out);
                check_value(name, "latency", calc_latency, cycle_cnt - start_cycle);
                tests_run++;
                if (fail_count == errs_before) begin
                    $display("test %s: pass", name);
                end else begin
                    $display("test %s: failed", name);
                    tests_failed++;
                end
            end
        end
    end

    initial begin : stimulus
        int total_cycles;
        bit wide;
        reset   = 1'b1;
        start   = 1'b0;
        x_elem  = '0;
        z_elem  = '0;
        x_focus = '0;
        z_focus = '0;
        elem    = '0;

        add_case("small 3-4-5", 0, 0, 3, 4, 1, 1, 1);
        add_case("scaled 3-4-5", 0, 0, 300, 400, 2, 125, 2);
        add_case("same point", 1234, -567, 1234, -567, 3, 0, 2);
        add_case("x axis", 100, 0, 1100, 0, 4, 250, 1);
        add_case("z axis", 0, -200, 0, 600, 5, 200, 1);
        add_case("mirror both", 0, 0, -300, -400, 6, 125, 0);
        add_case("mirror x", 0, 0, -300, 400, 7, 125, 0);
        add_case("swapped points", 300, 400, 0, 0, 8, 125, 3);
        add_case("floor of root", 0, 0, 1003, 32, 9, 250, 1);
        add_case("unit diagonal", 5, 5, 6, 6, 10, 0, 0);
        add_case("sub-sample", 0, 0, 7, 0, 11, 1, 0);
        add_case("largest unsaturated", 0, 0, 1023, 0, 12, 255, 1);
        add_case("first saturated", 0, 0, 1024, 0, 13, 255, 1);
        add_case("corner to corner", -32768, -32768, 32767, 32767, 14, 255, 0);
        add_case("opposite corners", 32767, -32768, -32768, 32767, 15, 255, 2);
        for (int b = 0; b < 8; b++) begin
            add_case($sformatf("burst_%0d", b), b * 100, 0, b * 100, 400 + 40 * b,
                     100 + b, 100 + 10 * b, (b == 7) ? 2 : 0);
        end

        for (int r = 0; r < random_count; r++) begin
            wide = r[0];
            name_q.push_back($sformatf("random_%0d", r));
            xe_q.push_back(rand_coord(wide));
            ze_q.push_back(rand_coord(wide));
            xf_q.push_back(rand_coord(wide));
            zf_q.push_back(rand_coord(wide));
            tag_q.push_back(elem_w'($random(seed)));
            delay_q.push_back(ref_delay(xe_q[$], ze_q[$], xf_q[$], zf_q[$]));
            gap_q.push_back($random(seed) & 3);
        end

        total_cycles = reset_cycles;
        foreach (gap_q[i]) total_cycles += 1 + gap_q[i];
        limit_cycles = total_cycles + calc_latency + margin_cycles;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        foreach (name_q[i]) begin
            @(posedge clk);
            start   <= 1'b1;
            x_elem  <= xe_q[i];
            z_elem  <= ze_q[i];
            x_focus <= xf_q[i];
            z_focus <= zf_q[i];
            elem    <= tag_q[i];
            pend_name_q.push_back(name_q[i]);
            pend_delay_q.push_back(delay_q[i]);
            pend_tag_q.push_back(int'(tag_q[i]));
            repeat (gap_q[i]) begin
                @(posedge clk);
                start <= 1'b0;
            end
        end
        @(posedge clk);
        start <= 1'b0;

        while (pend_delay_q.size() != 0) @(posedge clk);
        repeat (calc_latency + 4) @(posedge clk);    // Any stray done shows up here.

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        #(limit_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/delay_pkg.sv
rtl/dist_if.sv
rtl/delay_decode.sv
rtl/dist_square_sum.sv
rtl/isqrt_pipe.sv
rtl/delay_result.sv
rtl/delay_calc_top.sv
tests/delay_calc_tb.sv

// ==== Bender.yml ====
package:
  name: delay_calc

sources:
  # RTL in compile order.
  - rtl/delay_pkg.sv
  - rtl/dist_if.sv
  - rtl/delay_decode.sv
  - rtl/dist_square_sum.sv
  - rtl/isqrt_pipe.sv
  - rtl/delay_result.sv
  - rtl/delay_calc_top.sv

  # Testbench.
  - target: test
    files:
      - tests/delay_calc_tb.sv
